/* Makefile */
TOP = exu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/exu.sv */
`timescale 1ns/1ps

module exu
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    input  logic       int_assert_i,
    input  logic       int_jump_i,
    input  inst_addr_t int_addr_i,

    // lane 0 request and writeback
    input  logic       req_alu0_i,
    input  xlen_t      alu0_op1_i,
    input  xlen_t      alu0_op2_i,
    input  alu_op_e    alu0_op_i,
    input  reg_addr_t  alu0_rd_i,
    input  commit_id_t alu0_commit_id_i,
    input  logic       alu0_wb_ready_i,
    output xlen_t      alu0_reg_wdata_o,
    output logic       alu0_reg_we_o,
    output reg_addr_t  alu0_reg_waddr_o,
    output commit_id_t alu0_commit_id_o,

    // lane 1 request and writeback
    input  logic       req_alu1_i,
    input  xlen_t      alu1_op1_i,
    input  xlen_t      alu1_op2_i,
    input  alu_op_e    alu1_op_i,
    input  reg_addr_t  alu1_rd_i,
    input  commit_id_t alu1_commit_id_i,
    input  logic       alu1_wb_ready_i,
    output xlen_t      alu1_reg_wdata_o,
    output logic       alu1_reg_we_o,
    output reg_addr_t  alu1_reg_waddr_o,
    output commit_id_t alu1_commit_id_o,

    // branch request
    input  logic       req_bjp_i,
    input  xlen_t      bjp_op1_i,
    input  xlen_t      bjp_op2_i,
    input  inst_addr_t bjp_jump_op1_i,
    input  inst_addr_t bjp_jump_op2_i,
    input  bru_op_e    bjp_op_i,

    output logic       stall_flag_o,
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o,
    output logic       misaligned_fetch_o
);

    logic       alu0_stall;
    logic       alu1_stall;
    logic       bru_taken;
    inst_addr_t bru_target;
    logic       bru_misaligned;

    exu_alu u_alu0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_alu_i    (req_alu0_i),
        .alu_op1_i    (alu0_op1_i),
        .alu_op2_i    (alu0_op2_i),
        .alu_op_i     (alu0_op_i),
        .alu_rd_i     (alu0_rd_i),
        .commit_id_i  (alu0_commit_id_i),
        .wb_ready_i   (alu0_wb_ready_i),
        .int_assert_i (int_assert_i),
        .result_o     (alu0_reg_wdata_o),
        .reg_we_o     (alu0_reg_we_o),
        .reg_waddr_o  (alu0_reg_waddr_o),
        .commit_id_o  (alu0_commit_id_o),
        .alu_stall_o  (alu0_stall)
    );

    exu_alu u_alu1 (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_alu_i    (req_alu1_i),
        .alu_op1_i    (alu1_op1_i),
        .alu_op2_i    (alu1_op2_i),
        .alu_op_i     (alu1_op_i),
        .alu_rd_i     (alu1_rd_i),
        .commit_id_i  (alu1_commit_id_i),
        .wb_ready_i   (alu1_wb_ready_i),
        .int_assert_i (int_assert_i),
        .result_o     (alu1_reg_wdata_o),
        .reg_we_o     (alu1_reg_we_o),
        .reg_waddr_o  (alu1_reg_waddr_o),
        .commit_id_o  (alu1_commit_id_o),
        .alu_stall_o  (alu1_stall)
    );

    exu_bru u_bru (
        .req_bjp_i      (req_bjp_i),
        .bjp_op1_i      (bjp_op1_i),
        .bjp_op2_i      (bjp_op2_i),
        .bjp_jump_op1_i (bjp_jump_op1_i),
        .bjp_jump_op2_i (bjp_jump_op2_i),
        .bjp_op_i       (bjp_op_i),
        .taken_o        (bru_taken),
        .target_o       (bru_target),
        .misaligned_o   (bru_misaligned)
    );

    exu_ctrl u_ctrl (
        .clk                (clk),
        .rst_i              (rst_i),
        .alu0_stall_i       (alu0_stall),
        .alu1_stall_i       (alu1_stall),
        .bru_taken_i        (bru_taken),
        .bru_target_i       (bru_target),
        .bru_misaligned_i   (bru_misaligned),
        .int_jump_i         (int_jump_i),
        .int_addr_i         (int_addr_i),
        .stall_flag_o       (stall_flag_o),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o),
        .misaligned_fetch_o (misaligned_fetch_o)
    );

endmodule

/* logic/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    // request from dispatch
    input  logic       req_alu_i,
    input  xlen_t      alu_op1_i,
    input  xlen_t      alu_op2_i,
    input  alu_op_e    alu_op_i,
    input  reg_addr_t  alu_rd_i,
    input  commit_id_t commit_id_i,

    input  logic       wb_ready_i,
    input  logic       int_assert_i,

    // writeback side
    output xlen_t      result_o,
    output logic       reg_we_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o,
    output logic       alu_stall_o
);

    xlen_t      alu_result;
    logic [4:0] shamt;
    logic       accept;

    assign shamt = alu_op2_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_result = alu_op1_i + alu_op2_i;
            ALU_SUB:  alu_result = alu_op1_i - alu_op2_i;
            ALU_AND:  alu_result = alu_op1_i & alu_op2_i;
            ALU_OR:   alu_result = alu_op1_i | alu_op2_i;
            ALU_XOR:  alu_result = alu_op1_i ^ alu_op2_i;
            ALU_SLL:  alu_result = alu_op1_i << shamt;
            ALU_SRL:  alu_result = alu_op1_i >> shamt;
            ALU_SRA:  alu_result = xlen_t'($signed(alu_op1_i) >>> shamt);
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}},
                                    $signed(alu_op1_i) < $signed(alu_op2_i)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, alu_op1_i < alu_op2_i};
            default:  alu_result = '0;
        endcase
    end

    // held result not yet taken by writeback
    assign alu_stall_o = reg_we_o && !wb_ready_i;

    assign accept = req_alu_i && !alu_stall_o && !int_assert_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_we_o <= 1'b0;
        end else if (int_assert_i) begin
            // interrupt drops whatever is held
            reg_we_o <= 1'b0;
        end else if (accept) begin
            reg_we_o <= 1'b1;
        end else if (wb_ready_i) begin
            reg_we_o <= 1'b0;
        end
    end

    // payload only moves on an accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            result_o    <= alu_result;
            reg_waddr_o <= alu_rd_i;
            commit_id_o <= commit_id_i;
        end
    end

endmodule

/* logic/exu_bru.sv */
`timescale 1ns/1ps

module exu_bru
    import exu_pkg::*;
(
    input  logic       req_bjp_i,

    // compare operands
    input  xlen_t      bjp_op1_i,
    input  xlen_t      bjp_op2_i,

    // target operands are pc or rs1 plus offset
    input  inst_addr_t bjp_jump_op1_i,
    input  inst_addr_t bjp_jump_op2_i,
    input  bru_op_e    bjp_op_i,

    output logic       taken_o,
    output inst_addr_t target_o,
    output logic       misaligned_o
);

    logic       op_equal;
    logic       op_lt_signed;
    logic       op_lt_unsigned;
    logic       cond;
    inst_addr_t target_sum;

    assign op_equal       = (bjp_op1_i == bjp_op2_i);
    assign op_lt_signed   = $signed(bjp_op1_i) < $signed(bjp_op2_i);
    assign op_lt_unsigned = bjp_op1_i < bjp_op2_i;

    always_comb begin
        case (bjp_op_i)
            BRU_JAL:  cond = 1'b1;
            BRU_JALR: cond = 1'b1;
            BRU_BEQ:  cond = op_equal;
            BRU_BNE:  cond = !op_equal;
            BRU_BLT:  cond = op_lt_signed;
            BRU_BGE:  cond = !op_lt_signed;
            BRU_BLTU: cond = op_lt_unsigned;
            BRU_BGEU: cond = !op_lt_unsigned;
            default:  cond = 1'b0;
        endcase
    end

    assign taken_o = req_bjp_i && cond;

    assign target_sum = bjp_jump_op1_i + bjp_jump_op2_i;

    // jalr drops the low bit of the sum
    always_comb begin
        target_o = target_sum;
        if (bjp_op_i == BRU_JALR) begin
            target_o[0] = 1'b0;
        end
    end

    // without compressed instructions bit 1 must be clear
    assign misaligned_o = taken_o && target_o[1];

endmodule

/* logic/exu_ctrl.sv */
`timescale 1ns/1ps

module exu_ctrl
    import exu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    // lane back-pressure
    input  logic       alu0_stall_i,
    input  logic       alu1_stall_i,

    // branch unit decision
    input  logic       bru_taken_i,
    input  inst_addr_t bru_target_i,
    input  logic       bru_misaligned_i,

    // interrupt redirect
    input  logic       int_jump_i,
    input  inst_addr_t int_addr_i,

    output logic       stall_flag_o,
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o,
    output logic       misaligned_fetch_o
);

    assign stall_flag_o = alu0_stall_i | alu1_stall_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            jump_flag_o        <= 1'b0;
            misaligned_fetch_o <= 1'b0;
        end else begin
            jump_flag_o        <= int_jump_i | bru_taken_i;
            // interrupt vector is never flagged misaligned
            misaligned_fetch_o <= !int_jump_i && bru_misaligned_i;
        end
    end

    // interrupt wins over a branch in the same cycle
    always_ff @(posedge clk) begin
        if (int_jump_i) begin
            jump_addr_o <= int_addr_i;
        end else begin
            jump_addr_o <= bru_target_i;
        end
    end

endmodule

/* logic/exu_pkg.sv */
package exu_pkg;

    localparam int XLEN = 32;

    // operand and result word
    typedef logic [XLEN-1:0] xlen_t;

    // instruction fetch address
    typedef logic [31:0] inst_addr_t;

    // destination register index
    typedef logic [4:0] reg_addr_t;

    // tag of an in-flight instruction
    typedef logic [2:0] commit_id_t;

    // alu operation (shifts take op2[4:0])
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // branch and jump operation
    typedef enum logic [2:0] {
        BRU_JAL  = 3'd0,
        BRU_JALR = 3'd1,
        BRU_BEQ  = 3'd2,
        BRU_BNE  = 3'd3,
        BRU_BLT  = 3'd4,
        BRU_BGE  = 3'd5,
        BRU_BLTU = 3'd6,
        BRU_BGEU = 3'd7
    } bru_op_e;

endpackage

/* sources.f */
+incdir+verification
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_bru.sv
logic/exu_ctrl.sv
logic/exu.sv
verification/exu_assertions.sv
verification/exu_tb.sv

/* verification/exu_assertions.sv */
`timescale 1ns/1ps

module exu_assertions
    import exu_pkg::*;
(
    input logic       clk,
    input logic       rst_i,
    input logic       int_assert_i,
    input logic       alu_stall_o,
    input logic       reg_we_o,
    input xlen_t      result_o,
    input reg_addr_t  reg_waddr_o,
    input commit_id_t commit_id_o
);

    // stalled lane keeps its whole writeback payload
    property held_while_stalled;
        @(posedge clk) disable iff (rst_i)
            alu_stall_o && !int_assert_i |=> reg_we_o && $stable(result_o)
                && $stable(reg_waddr_o) && $stable(commit_id_o);
    endproperty

    assert property (held_while_stalled)
        else $error("lane result changed while stalled");

    assert property (@(posedge clk) rst_i |=> !reg_we_o)
        else $error("reg_we_o high in the cycle after reset");

endmodule

bind exu_alu exu_assertions u_exu_assertions (
    .clk          (clk),
    .rst_i        (rst_i),
    .int_assert_i (int_assert_i),
    .alu_stall_o  (alu_stall_o),
    .reg_we_o     (reg_we_o),
    .result_o     (result_o),
    .reg_waddr_o  (reg_waddr_o),
    .commit_id_o  (commit_id_o)
);

/* verification/exu_tb_tasks.svh */
// advance to the drive point just after the next rising edge
task automatic step();
    @(posedge clk);
    #2;
endtask

task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_data(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_addr(string name, inst_addr_t got, inst_addr_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_reg_addr(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_commit_id(string name, commit_id_t got, commit_id_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

// expected alu result
function automatic xlen_t alu_expect(alu_op_e op, xlen_t a, xlen_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLL:  return a << sh;
        ALU_SRL:  return a >> sh;
        ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
        ALU_SLT:  return ((a[31] != b[31]) ? a[31] : (a < b)) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        default:  return 32'd0;
    endcase
endfunction

function automatic logic branch_taken(bru_op_e op, xlen_t a, xlen_t b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (op)
        BRU_BEQ:  return a == b;
        BRU_BNE:  return a != b;
        BRU_BLT:  return lt_s;
        BRU_BGE:  return !lt_s;
        BRU_BLTU: return a < b;
        BRU_BGEU: return a >= b;
        default:  return 1'b1;
    endcase
endfunction

function automatic inst_addr_t branch_target(bru_op_e op, inst_addr_t j1, inst_addr_t j2);
    inst_addr_t sum;
    sum = j1 + j2;
    if (op == BRU_JALR) begin
        sum[0] = 1'b0;
    end
    return sum;
endfunction

task automatic drive_alu(int lane, alu_op_e op, xlen_t a, xlen_t b,
                         reg_addr_t rd, commit_id_t id);
    if (lane == 0) begin
        req_alu0_i       = 1'b1;
        alu0_op_i        = op;
        alu0_op1_i       = a;
        alu0_op2_i       = b;
        alu0_rd_i        = rd;
        alu0_commit_id_i = id;
    end else begin
        req_alu1_i       = 1'b1;
        alu1_op_i        = op;
        alu1_op1_i       = a;
        alu1_op2_i       = b;
        alu1_rd_i        = rd;
        alu1_commit_id_i = id;
    end
endtask

// steps at least once until every lane in mask shows reg_we at level
task automatic wait_reg_we(logic [1:0] mask, logic level, int limit);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
        step();
        cycles++;
        done = (!mask[0] || alu0_reg_we_o == level) && (!mask[1] || alu1_reg_we_o == level);
        if (!done && cycles >= limit) begin
            $display("timed out after %0d cycles waiting for reg_we_o = %0b", cycles, level);
            abort_run();
        end
    end
endtask

task automatic check_lane(int lane, xlen_t data, reg_addr_t rd, commit_id_t id);
    if (lane == 0) begin
        check_flag("alu0_reg_we_o", alu0_reg_we_o, 1'b1);
        check_data("alu0_reg_wdata_o", alu0_reg_wdata_o, data);
        check_reg_addr("alu0_reg_waddr_o", alu0_reg_waddr_o, rd);
        check_commit_id("alu0_commit_id_o", alu0_commit_id_o, id);
    end else begin
        check_flag("alu1_reg_we_o", alu1_reg_we_o, 1'b1);
        check_data("alu1_reg_wdata_o", alu1_reg_wdata_o, data);
        check_reg_addr("alu1_reg_waddr_o", alu1_reg_waddr_o, rd);
        check_commit_id("alu1_commit_id_o", alu1_commit_id_o, id);
    end
endtask

task automatic run_branch(bru_op_e op, xlen_t a, xlen_t b, inst_addr_t j1, inst_addr_t j2);
    logic       taken;
    inst_addr_t target;
    taken          = branch_taken(op, a, b);
    target         = branch_target(op, j1, j2);
    req_bjp_i      = 1'b1;
    bjp_op_i       = op;
    bjp_op1_i      = a;
    bjp_op2_i      = b;
    bjp_jump_op1_i = j1;
    bjp_jump_op2_i = j2;
    step();
    check_flag("jump_flag_o", jump_flag_o, taken);
    if (taken) begin
        check_addr("jump_addr_o", jump_addr_o, target);
    end
    check_flag("misaligned_fetch_o", misaligned_fetch_o, taken && target[1]);
    req_bjp_i = 1'b0;
    // redirect lasts a single cycle
    step();
    check_flag("jump_flag_o", jump_flag_o, 1'b0);
endtask

task automatic test_reset();
    check_flag("stall_flag_o", stall_flag_o, 1'b0);
    check_flag("jump_flag_o", jump_flag_o, 1'b0);
    check_flag("misaligned_fetch_o", misaligned_fetch_o, 1'b0);
    check_flag("alu0_reg_we_o", alu0_reg_we_o, 1'b0);
    check_flag("alu1_reg_we_o", alu1_reg_we_o, 1'b0);
endtask

// every op twice on both lanes with back to back issue
task automatic test_alu_ops();
    int         i;
    alu_op_e    op;
    xlen_t      a0, b0, a1, b1;
    reg_addr_t  rd0, rd1;
    commit_id_t id0, id1;
    for (i = 0; i < 20; i++) begin
        op  = alu_op_e'(i % 10);
        a0  = $urandom();
        b0  = $urandom();
        a1  = $urandom();
        b1  = $urandom();
        rd0 = reg_addr_t'($urandom());
        rd1 = reg_addr_t'($urandom());
        id0 = commit_id_t'($urandom());
        id1 = commit_id_t'($urandom());
        drive_alu(0, op, a0, b0, rd0, id0);
        drive_alu(1, op, a1, b1, rd1, id1);
        wait_reg_we(2'b11, 1'b1, 1);
        check_lane(0, alu_expect(op, a0, b0), rd0, id0);
        check_lane(1, alu_expect(op, a1, b1), rd1, id1);
        check_flag("stall_flag_o", stall_flag_o, 1'b0);
    end
    req_alu0_i = 1'b0;
    req_alu1_i = 1'b0;
    wait_reg_we(2'b11, 1'b0, 1);
endtask

task automatic test_back_pressure();
    int    n;
    xlen_t a, b;
    a = $urandom();
    b = $urandom();
    alu1_wb_ready_i = 1'b0;
    drive_alu(1, ALU_XOR, a, b, 5'd7, 3'd2);
    wait_reg_we(2'b10, 1'b1, 1);
    req_alu1_i = 1'b0;
    for (n = 0; n < 4; n++) begin
        check_lane(1, alu_expect(ALU_XOR, a, b), 5'd7, 3'd2);
        check_flag("stall_flag_o", stall_flag_o, 1'b1);
        step();
    end
    alu1_wb_ready_i = 1'b1;
    wait_reg_we(2'b10, 1'b0, 1);
    check_flag("stall_flag_o", stall_flag_o, 1'b0);
endtask

task automatic test_branches();
    inst_addr_t base;
    inst_addr_t offs;
    // word aligned pieces keep the sum aligned
    base = inst_addr_t'($urandom()) & 32'hFFFF_FFFC;
    offs = inst_addr_t'($urandom()) & 32'h0000_0FFC;
    run_branch(BRU_BEQ,  32'd5, 32'd5, base, offs);
    run_branch(BRU_BEQ,  32'd5, 32'd6, base, offs);
    run_branch(BRU_BNE,  32'd5, 32'd6, base, offs);
    run_branch(BRU_BNE,  32'd9, 32'd9, base, offs);
    run_branch(BRU_BLT,  32'hFFFF_FFFF, 32'd1, base, offs);
    run_branch(BRU_BLT,  32'd1, 32'hFFFF_FFFF, base, offs);
    run_branch(BRU_BGE,  32'd1, 32'hFFFF_FFFF, base, offs);
    run_branch(BRU_BGE,  32'h8000_0000, 32'd0, base, offs);
    run_branch(BRU_BLTU, 32'd1, 32'hFFFF_FFFF, base, offs);
    run_branch(BRU_BLTU, 32'hFFFF_FFFF, 32'd1, base, offs);
    run_branch(BRU_BGEU, 32'hFFFF_FFFF, 32'd1, base, offs);
    run_branch(BRU_BGEU, 32'd1, 32'hFFFF_FFFF, base, offs);
endtask

task automatic test_jump_targets();
    run_branch(BRU_JALR, '0, '0, 32'h0000_2001, 32'h0000_0010);
    run_branch(BRU_JAL,  '0, '0, 32'h0000_1000, 32'h0000_0002);
    run_branch(BRU_JALR, '0, '0, 32'h0000_3001, 32'h0000_0002);
endtask

task automatic test_interrupts();
    inst_addr_t vec;
    vec = 32'h8000_0100;
    // interrupt overrides a taken jal to a misaligned target
    req_bjp_i      = 1'b1;
    bjp_op_i       = BRU_JAL;
    bjp_jump_op1_i = 32'h0000_4000;
    bjp_jump_op2_i = 32'h0000_0006;
    int_jump_i     = 1'b1;
    int_addr_i     = vec;
    step();
    check_flag("jump_flag_o", jump_flag_o, 1'b1);
    check_addr("jump_addr_o", jump_addr_o, vec);
    check_flag("misaligned_fetch_o", misaligned_fetch_o, 1'b0);
    req_bjp_i  = 1'b0;
    int_jump_i = 1'b0;

    alu0_wb_ready_i = 1'b0;
    drive_alu(0, ALU_ADD, 32'd1, 32'd2, 5'd3, 3'd4);
    wait_reg_we(2'b01, 1'b1, 1);
    req_alu0_i = 1'b0;
    check_flag("stall_flag_o", stall_flag_o, 1'b1);
    int_assert_i = 1'b1;
    wait_reg_we(2'b01, 1'b0, 1);
    check_flag("stall_flag_o", stall_flag_o, 1'b0);
    int_assert_i    = 1'b0;
    alu0_wb_ready_i = 1'b1;
endtask

/* verification/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb
    import exu_pkg::*;
();

    logic       clk;
    logic       rst_i;
    logic       int_assert_i, int_jump_i, req_bjp_i;
    logic       req_alu0_i, alu0_wb_ready_i, alu0_reg_we_o;
    logic       req_alu1_i, alu1_wb_ready_i, alu1_reg_we_o;
    logic       stall_flag_o, jump_flag_o, misaligned_fetch_o;
    inst_addr_t int_addr_i, bjp_jump_op1_i, bjp_jump_op2_i, jump_addr_o;
    xlen_t      alu0_op1_i, alu0_op2_i, alu0_reg_wdata_o;
    xlen_t      alu1_op1_i, alu1_op2_i, alu1_reg_wdata_o;
    xlen_t      bjp_op1_i, bjp_op2_i;
    alu_op_e    alu0_op_i, alu1_op_i;
    bru_op_e    bjp_op_i;
    reg_addr_t  alu0_rd_i, alu0_reg_waddr_o, alu1_rd_i, alu1_reg_waddr_o;
    commit_id_t alu0_commit_id_i, alu0_commit_id_o;
    commit_id_t alu1_commit_id_i, alu1_commit_id_o;

    exu u_exu (.*);

    `include "exu_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        void'($urandom(46));
        rst_i            = 1'b1;
        int_assert_i     = 1'b0;
        int_jump_i       = 1'b0;
        int_addr_i       = '0;
        req_alu0_i       = 1'b0;
        alu0_op1_i       = '0;
        alu0_op2_i       = '0;
        alu0_op_i        = ALU_ADD;
        alu0_rd_i        = '0;
        alu0_commit_id_i = '0;
        alu0_wb_ready_i  = 1'b1;
        req_alu1_i       = 1'b0;
        alu1_op1_i       = '0;
        alu1_op2_i       = '0;
        alu1_op_i        = ALU_ADD;
        alu1_rd_i        = '0;
        alu1_commit_id_i = '0;
        alu1_wb_ready_i  = 1'b1;
        req_bjp_i        = 1'b0;
        bjp_op1_i        = '0;
        bjp_op2_i        = '0;
        bjp_jump_op1_i   = '0;
        bjp_jump_op2_i   = '0;
        bjp_op_i         = BRU_BEQ;

        // hold reset over three rising edges
        repeat (3) @(posedge clk);
        #2;
        test_reset();
        rst_i = 1'b0;

        test_alu_ops();
        test_back_pressure();
        test_branches();
        test_jump_targets();
        test_interrupts();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
